//--- verilog/dbg_map_pkg.sv
////////////////////////////////////////
// Debug map package
// Address map, offsets, bit positions
////////////////////////////////////////
`default_nettype none

package dbg_map_pkg;

  // Data and address widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;

  // Region codes in the top address bits
  localparam logic [4:0] REGION_DBG = 5'b00110;
  localparam logic [5:0] REGION_GPR = 6'b000001;

  // Offsets inside the debug space
  localparam logic [10:0] OFF_NPC  = 11'd0;
  localparam logic [10:0] OFF_PPC  = 11'd1;
  localparam logic [10:0] OFF_DMR1 = 11'd16;
  localparam logic [10:0] OFF_DSR  = 11'd20;

  // DMR1 single-step bit, lower bit of a two bit field
  localparam int unsigned DMR1_ST_BIT = 22;
  // DSR stop field sits at bits 7:6
  localparam int unsigned DSR_LSB = 6;

  // Breakpoint control in the SPR bank
  localparam logic [11:0] SPR_BP_ADDR = 12'd8;
  localparam logic [11:0] SPR_BP_EN   = 12'd9;

endpackage

`default_nettype wire

//--- verilog/dbg_types_pkg.sv
////////////////////////////////////////
// Debug types package
// Request, control and address types
////////////////////////////////////////
`default_nettype none

package dbg_types_pkg;

  import dbg_map_pkg::*;

  // Debug space view of an address
  typedef struct packed {
    logic [4:0]  region;
    logic [10:0] offset;
  } dbg_view_t;

  // GPR view of the same address
  typedef struct packed {
    logic [5:0] region;
    logic [4:0] rsvd;
    logic [4:0] idx;
  } gpr_view_t;

  // One address word, two decodes
  typedef union packed {
    dbg_view_t dbg;
    gpr_view_t gpr;
  } dbg_addr_u;

  // Host request from the bus side
  typedef struct packed {
    logic              valid;
    logic              we;
    dbg_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } dbg_req_t;

  // Register port towards the core
  typedef struct packed {
    logic              gpr_sel;
    logic              spr_sel;
    logic              we;
    logic [11:0]       addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  // Pipeline control towards the core
  typedef struct packed {
    logic              stall;
    logic              flush;
    logic              set_npc;
    logic              step_en;
    logic [DATA_W-1:0] npc;
  } core_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/dbg_apb_slave.sv
////////////////////////////////////////
// APB slave for the debug port
// Maps access phases onto debug requests
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dbg_apb_slave
  import dbg_map_pkg::*;
  import dbg_types_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // APB side
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [DATA_W-1:0] pwdata_i,
  output logic [DATA_W-1:0] prdata_o,
  output logic              pready_o,

  // Controller side
  output dbg_req_t          req_o,
  input  logic              ack_i,
  input  logic [DATA_W-1:0] rdata_i
);

  // Setup phase seen, access not yet done
  logic xfer_pend_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      xfer_pend_q <= 1'b0;
    else if (psel_i && !penable_i)
      xfer_pend_q <= 1'b1;
    // Completing edge
    else if (psel_i && penable_i && ack_i)
      xfer_pend_q <= 1'b0;
  end

  // Request only for an access phase that followed its setup
  assign req_o.valid = psel_i && penable_i && xfer_pend_q;
  assign req_o.we    = pwrite_i;
  assign req_o.addr  = paddr_i;
  assign req_o.wdata = pwdata_i;

  // Wait states come straight from the ack
  assign pready_o = ack_i;
  assign prdata_o = rdata_i;

endmodule

`default_nettype wire

//--- verilog/dbg_ctrl_unit.sv
////////////////////////////////////////
// Debug controller
// Halt FSM, DMR1/DSR bank, address decode
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dbg_ctrl_unit
  import dbg_map_pkg::*;
  import dbg_types_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              halt_req_i,

  // Host request
  input  dbg_req_t          req_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,

  // Core side
  input  logic              trap_i,
  input  logic [DATA_W-1:0] pc_if_i,
  input  logic [DATA_W-1:0] pc_id_i,
  input  logic [DATA_W-1:0] reg_rdata_i,
  output core_ctrl_t        ctrl_o,
  output reg_req_t          reg_req_o,

  output logic              bp_hit_o
);

  typedef enum logic [1:0] {IDLE, DEBUG_STALL, STALL_CORE} halt_state_e;

  halt_state_e state_q, state_d;

  // DMR1 keeps ST and BT, DSR the two stop bits
  logic [1:0] dmr1_q, dmr1_d;
  logic [1:0] dsr_q, dsr_d;

  logic stalled;
  logic flush;
  logic set_npc;
  logic dbg_hit;

  ////////////////////////////////////////
  // Halt FSM
  ////////////////////////////////////////

  // Stall only once settled in StallCore
  assign stalled = (state_q == STALL_CORE);

  always_comb
  begin
    state_d  = state_q;
    flush    = 1'b0;
    bp_hit_o = 1'b0;
    case (state_q)
      IDLE:
      begin
        // Breakpoint or step trap skips the drain
        if (trap_i)
        begin
          bp_hit_o = 1'b1;
          state_d  = STALL_CORE;
        end
        else if (halt_req_i)
        begin
          flush   = 1'b1;
          state_d = DEBUG_STALL;
        end
      end
      DEBUG_STALL:
      begin
        // Hold flush until the core reports drained
        flush = 1'b1;
        if (trap_i)
          state_d = STALL_CORE;
      end
      STALL_CORE:
      begin
        if (!halt_req_i)
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign dbg_hit = (req_i.addr.dbg.region == REGION_DBG);

  // Debug space never waits, GPR/SPR only while halted
  assign ack_o = req_i.valid && (dbg_hit || stalled);

  always_comb
  begin
    dmr1_d          = dmr1_q;
    dsr_d           = dsr_q;
    set_npc         = 1'b0;
    rdata_o         = '0;
    reg_req_o       = '0;
    reg_req_o.wdata = req_i.wdata;
    if (req_i.valid)
    begin
      if (dbg_hit)
      begin
        case (req_i.addr.dbg.offset)
          OFF_NPC:
          begin
            set_npc = req_i.we;
            rdata_o = pc_if_i;
          end
          OFF_PPC:
          begin
            rdata_o = pc_id_i;
          end
          OFF_DMR1:
          begin
            if (req_i.we)
              dmr1_d = req_i.wdata[DMR1_ST_BIT +: 2];
            else
              rdata_o[DMR1_ST_BIT +: 2] = dmr1_q;
          end
          OFF_DSR:
          begin
            if (req_i.we)
              dsr_d = req_i.wdata[DSR_LSB +: 2];
            else
              rdata_o[DSR_LSB +: 2] = dsr_q;
          end
          default: ;
        endcase
      end
      else if (stalled)
      begin
        // GPR region, else falls through to SPR bank
        if (req_i.addr.gpr.region == REGION_GPR)
        begin
          reg_req_o.gpr_sel = 1'b1;
          reg_req_o.addr    = {7'b0, req_i.addr.gpr.idx};
        end
        else
        begin
          reg_req_o.spr_sel = 1'b1;
          reg_req_o.addr    = req_i.addr[11:0];
        end
        reg_req_o.we = req_i.we;
        if (!req_i.we)
          rdata_o = reg_rdata_i;
      end
    end
  end

  // Core control bundle
  assign ctrl_o.stall   = stalled;
  assign ctrl_o.flush   = flush;
  assign ctrl_o.set_npc = set_npc;
  assign ctrl_o.step_en = dmr1_q[0];
  assign ctrl_o.npc     = req_i.wdata;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      dmr1_q  <= 2'b0;
      dsr_q   <= 2'b0;
    end
    else
    begin
      state_q <= state_d;
      dmr1_q  <= dmr1_d;
      dsr_q   <= dsr_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_state_model.sv
////////////////////////////////////////
// Core state model
// Register files, PCs and debug traps
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_state_model
  import dbg_map_pkg::*;
  import dbg_types_pkg::*;
#(
  parameter logic [DATA_W-1:0] RESET_PC = '0,
  parameter int unsigned       NUM_SPR  = 16
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  core_ctrl_t        ctrl_i,
  input  reg_req_t          reg_req_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              trap_o,
  output logic [DATA_W-1:0] pc_if_o,
  output logic [DATA_W-1:0] pc_id_o
);

  localparam int unsigned SPR_AW = $clog2(NUM_SPR);
  localparam logic [SPR_AW-1:0] BP_ADDR_IDX = SPR_AW'(SPR_BP_ADDR);
  localparam logic [SPR_AW-1:0] BP_EN_IDX   = SPR_AW'(SPR_BP_EN);

  logic [DATA_W-1:0] gpr_q [32];
  logic [DATA_W-1:0] spr_q [NUM_SPR];
  logic [DATA_W-1:0] pc_if_q, pc_id_q;
  logic              trap_q;

  logic              spr_hit;
  logic [SPR_AW-1:0] spr_idx;
  logic              bp_match;
  logic              pc_adv;
  logic              trap_set;

  ////////////////////////////////////////
  // Register files
  ////////////////////////////////////////

  // Indices past the bank read zero
  assign spr_hit = (32'(reg_req_i.addr) < NUM_SPR);
  assign spr_idx = reg_req_i.addr[SPR_AW-1:0];

  always_ff @(posedge clk)
  begin
    if (reg_req_i.gpr_sel && reg_req_i.we)
      gpr_q[reg_req_i.addr[4:0]] <= reg_req_i.wdata;
  end

  // SPR bank holds breakpoint control
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_SPR; i++)
        spr_q[i] <= '0;
    end
    else if (reg_req_i.spr_sel && reg_req_i.we && spr_hit)
      spr_q[spr_idx] <= reg_req_i.wdata;
  end

  always_comb
  begin
    rdata_o = '0;
    if (reg_req_i.gpr_sel)
      rdata_o = gpr_q[reg_req_i.addr[4:0]];
    else if (reg_req_i.spr_sel && spr_hit)
      rdata_o = spr_q[spr_idx];
  end

  ////////////////////////////////////////
  // Program counters and traps
  ////////////////////////////////////////

  // Fetch stops on the matching address
  assign bp_match = spr_q[BP_EN_IDX][0] && (pc_if_q == spr_q[BP_ADDR_IDX]);
  assign pc_adv   = !ctrl_i.stall && !ctrl_i.flush && !trap_q && !bp_match;

  // Drain done, step taken or breakpoint reached
  assign trap_set = ctrl_i.flush || (ctrl_i.step_en && pc_adv) || bp_match;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_if_q <= RESET_PC;
      pc_id_q <= RESET_PC;
    end
    // Redirect loads both stages
    else if (ctrl_i.set_npc)
    begin
      pc_if_q <= ctrl_i.npc;
      pc_id_q <= ctrl_i.npc;
    end
    else if (pc_adv)
    begin
      pc_id_q <= pc_if_q;
      pc_if_q <= pc_if_q + DATA_W'(4);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      trap_o <= 1'b0;
    // Cleared while halted so the release starts clean
    else if (ctrl_i.stall)
      trap_o <= 1'b0;
    else if (trap_set)
      trap_o <= 1'b1;
  end

  assign trap_q  = trap_o;
  assign pc_if_o = pc_if_q;
  assign pc_id_o = pc_id_q;

endmodule

`default_nettype wire

//--- verilog/dbg_subsys_top.sv
////////////////////////////////////////
// Debug subsystem top
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dbg_subsys_top
  import dbg_map_pkg::*;
  import dbg_types_pkg::*;
#(
  parameter logic [DATA_W-1:0] RESET_PC = 32'h0000_0200,
  parameter int unsigned       NUM_SPR  = 16
)
(
  input  logic              clk,
  input  logic              rst_n,

  // APB host port
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [DATA_W-1:0] pwdata_i,
  output logic [DATA_W-1:0] prdata_o,
  output logic              pready_o,

  // Halt handshake
  input  logic              halt_req_i,
  output logic              halted_o,
  output logic              bp_hit_o
);

  dbg_req_t          dbg_req;
  logic              dbg_ack;
  logic [DATA_W-1:0] dbg_rdata;

  core_ctrl_t        core_ctrl;
  reg_req_t          reg_req;
  logic              trap;
  logic [DATA_W-1:0] reg_rdata;
  logic [DATA_W-1:0] pc_if;
  logic [DATA_W-1:0] pc_id;

  dbg_apb_slave i_apb_slave (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .req_o     (dbg_req),
    .ack_i     (dbg_ack),
    .rdata_i   (dbg_rdata)
  );

  dbg_ctrl_unit i_ctrl_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .halt_req_i  (halt_req_i),
    .req_i       (dbg_req),
    .ack_o       (dbg_ack),
    .rdata_o     (dbg_rdata),
    .trap_i      (trap),
    .pc_if_i     (pc_if),
    .pc_id_i     (pc_id),
    .reg_rdata_i (reg_rdata),
    .ctrl_o      (core_ctrl),
    .reg_req_o   (reg_req),
    .bp_hit_o    (bp_hit_o)
  );

  core_state_model #(
    .RESET_PC (RESET_PC),
    .NUM_SPR  (NUM_SPR)
  ) i_core_state (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_i    (core_ctrl),
    .reg_req_i (reg_req),
    .rdata_o   (reg_rdata),
    .trap_o    (trap),
    .pc_if_o   (pc_if),
    .pc_id_o   (pc_id)
  );

  // Core stall doubles as the halted flag
  assign halted_o = core_ctrl.stall;

endmodule

`default_nettype wire

//--- tests/tb_dbg_subsys.sv
////////////////////////////////////////
// Debug subsystem testbench
// APB driven halt, step, breakpoint checks
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_dbg_subsys
  import dbg_map_pkg::*;
();

  localparam logic [31:0] RESET_PC    = 32'h0000_0200;
  localparam int          NUM_SPR     = 16;
  localparam int          TIMEOUT_CYC = 50;

  // Debug space addresses
  localparam logic [15:0] NPC_ADDR  = {REGION_DBG, OFF_NPC};
  localparam logic [15:0] PPC_ADDR  = {REGION_DBG, OFF_PPC};
  localparam logic [15:0] DMR1_ADDR = {REGION_DBG, OFF_DMR1};
  localparam logic [15:0] DSR_ADDR  = {REGION_DBG, OFF_DSR};

  // Visible bits of DSR and DMR1
  localparam logic [31:0] DSR_MASK = 32'h3 << DSR_LSB;
  localparam logic [31:0] ST_MASK  = 32'h1 << DMR1_ST_BIT;

  typedef enum logic {OP_READ, OP_WRITE} op_e;

  typedef struct packed {
    op_e         op;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] expected;
  } stim_entry_t;

  logic        clk;
  logic        rst_n;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [15:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        halt_req_i;
  logic        halted_o;
  logic        bp_hit_o;

  stim_entry_t stim_q [$];
  logic [31:0] gpr_exp [$];
  int          seed;
  int          err_cnt;
  int          check_cnt;
  logic [31:0] rd_val;
  logic [31:0] npc_val;
  logic [31:0] ppc_val;
  logic [31:0] pc_before;
  logic [31:0] new_pc;
  logic [31:0] bp_addr;

  dbg_subsys_top #(
    .RESET_PC (RESET_PC),
    .NUM_SPR  (NUM_SPR)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .halt_req_i (halt_req_i),
    .halted_o   (halted_o),
    .bp_hit_o   (bp_hit_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [15:0] gpr_addr(input int idx);
    return {REGION_GPR, 5'b0, 5'(idx)};
  endfunction

  // Top bits zero, outside debug and GPR regions
  function automatic logic [15:0] spr_addr(input int idx);
    return {4'b0, 12'(idx)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_cnt++;
    if (got !== expected)
    begin
      err_cnt++;
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, expected);
    end
  endtask

  // One APB transfer, stretched while pready is low
  task automatic apb_access(input logic we, input logic [15:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    @(posedge clk);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = we;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk);
    #1;
    penable_i = 1'b1;
    while (!done && cycles < TIMEOUT_CYC)
    begin
      @(negedge clk);
      if (pready_o)
      begin
        done  = 1'b1;
        rdata = prdata_o;
      end
      // Completing edge when pready was high
      @(posedge clk);
      cycles++;
    end
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    if (!done)
    begin
      err_cnt++;
      $display("Timeout: APB transfer to address 0x%04h never got pready", addr);
    end
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    apb_access(1'b1, addr, wdata, unused_rdata);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata);
    apb_access(1'b0, addr, '0, rdata);
  endtask

  task automatic halt_core();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    halt_req_i = 1'b1;
    @(negedge clk);
    while (!halted_o && cycles < TIMEOUT_CYC)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!halted_o)
    begin
      err_cnt++;
      $display("Timeout: core did not halt after halt request");
    end
  endtask

  task automatic release_core();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    halt_req_i = 1'b0;
    @(negedge clk);
    while (halted_o && cycles < TIMEOUT_CYC)
    begin
      @(negedge clk);
      cycles++;
    end
    if (halted_o)
    begin
      err_cnt++;
      $display("Timeout: core stayed halted after halt release");
    end
  endtask

  task automatic wait_bp_hit();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!bp_hit_o && cycles < TIMEOUT_CYC)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!bp_hit_o)
    begin
      err_cnt++;
      $display("Timeout: no breakpoint or step trap pulsed bp_hit_o");
    end
  endtask

  task automatic add_entry(input op_e op, input logic [15:0] addr,
                           input logic [31:0] wdata, input logic [31:0] expected);
    stim_entry_t ent;
    ent.op       = op;
    ent.addr     = addr;
    ent.wdata    = wdata;
    ent.expected = expected;
    stim_q.push_back(ent);
  endtask

  // Reset values, DSR/DMR1 masking, SPR range
  task automatic build_table();
    add_entry(OP_READ,  DSR_ADDR,  '0, 32'h0);
    add_entry(OP_READ,  DMR1_ADDR, '0, 32'h0);
    add_entry(OP_READ,  NPC_ADDR,  '0, RESET_PC);
    add_entry(OP_WRITE, DSR_ADDR,  32'hffff_ffff, '0);
    add_entry(OP_READ,  DSR_ADDR,  '0, DSR_MASK);
    add_entry(OP_WRITE, DSR_ADDR,  32'h1 << DSR_LSB, '0);
    add_entry(OP_READ,  DSR_ADDR,  '0, 32'h1 << DSR_LSB);
    add_entry(OP_WRITE, DSR_ADDR,  32'h0, '0);
    add_entry(OP_READ,  DSR_ADDR,  '0, 32'h0);
    add_entry(OP_WRITE, DMR1_ADDR, ST_MASK | 32'h0000_ffff, '0);
    add_entry(OP_READ,  DMR1_ADDR, '0, ST_MASK);
    add_entry(OP_WRITE, DMR1_ADDR, 32'h0, '0);
    add_entry(OP_READ,  DMR1_ADDR, '0, 32'h0);
    add_entry(OP_WRITE, spr_addr(0), 32'h1357_9bdf, '0);
    add_entry(OP_READ,  spr_addr(0), '0, 32'h1357_9bdf);
    add_entry(OP_WRITE, spr_addr(NUM_SPR), 32'ha5a5_5a5a, '0);
    add_entry(OP_READ,  spr_addr(NUM_SPR), '0, 32'h0);
    add_entry(OP_WRITE, spr_addr(NUM_SPR + 24), 32'h0f0f_f0f0, '0);
    add_entry(OP_READ,  spr_addr(NUM_SPR + 24), '0, 32'h0);
    // Out of range writes must leave SPR 0 untouched
    add_entry(OP_READ,  spr_addr(0), '0, 32'h1357_9bdf);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    seed      = 32'hf24a;
    err_cnt   = 0;
    check_cnt = 0;
    rst_n     = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    // Held through reset so the PC stays at RESET_PC
    halt_req_i = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    halt_core();

    // Table of register accesses
    build_table();
    for (int n = 0; n < stim_q.size(); n++)
    begin
      if (stim_q[n].op == OP_WRITE)
        apb_write(stim_q[n].addr, stim_q[n].wdata);
      else
      begin
        apb_read(stim_q[n].addr, rd_val);
        check_value($sformatf("prdata_o at 0x%04h", stim_q[n].addr), rd_val,
                    stim_q[n].expected);
      end
    end

    // Random GPR contents
    for (int i = 0; i < 32; i++)
    begin
      gpr_exp.push_back($random(seed));
      apb_write(gpr_addr(i), gpr_exp[i]);
    end
    for (int i = 0; i < 32; i++)
    begin
      apb_read(gpr_addr(i), rd_val);
      check_value($sformatf("gpr[%0d]", i), rd_val, gpr_exp[i]);
    end

    // NPC redirect, then one run and re-halt
    new_pc = ($random(seed) & 32'h0000_fffc) | 32'h0001_0000;
    apb_write(NPC_ADDR, new_pc);
    apb_read(NPC_ADDR, npc_val);
    check_value("npc", npc_val, new_pc);
    apb_read(PPC_ADDR, ppc_val);
    check_value("ppc", ppc_val, new_pc);
    release_core();
    repeat (6) @(posedge clk);
    halt_core();
    apb_read(NPC_ADDR, npc_val);
    apb_read(PPC_ADDR, ppc_val);
    check_value("npc_minus_ppc", npc_val - ppc_val, 32'd4);

    // Breakpoint six instructions ahead
    apb_read(NPC_ADDR, pc_before);
    bp_addr = pc_before + 32'd24;
    apb_write(spr_addr(int'(SPR_BP_ADDR)), bp_addr);
    apb_write(spr_addr(int'(SPR_BP_EN)), 32'h1);
    release_core();
    wait_bp_hit();
    // Pulse lasts one cycle, halted follows on the next edge
    @(negedge clk);
    check_value("bp_hit_o", 32'(bp_hit_o), 32'h0);
    check_value("halted_o at bp", 32'(halted_o), 32'h1);
    halt_core();
    apb_read(NPC_ADDR, npc_val);
    check_value("npc_at_bp", npc_val, bp_addr);
    apb_write(spr_addr(int'(SPR_BP_EN)), 32'h0);

    // Three single steps
    apb_write(DMR1_ADDR, ST_MASK);
    for (int s = 0; s < 3; s++)
    begin
      apb_read(NPC_ADDR, pc_before);
      release_core();
      // Core must stop on its own step trap
      wait_bp_hit();
      halt_core();
      apb_read(NPC_ADDR, npc_val);
      check_value($sformatf("npc_step%0d", s), npc_val, pc_before + 32'd4);
    end
    apb_write(DMR1_ADDR, 32'h0);

    // GPR read stalls while the core runs
    release_core();
    fork
      apb_read(gpr_addr(7), rd_val);
      begin
        for (int k = 0; k < 8; k++)
        begin
          @(negedge clk);
          check_value("pready_o", 32'(pready_o), 32'h0);
        end
        @(posedge clk);
        #1;
        halt_req_i = 1'b1;
      end
    join
    check_value("gpr[7] stalled read", rd_val, gpr_exp[7]);
    check_value("halted_o", 32'(halted_o), 32'h1);

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/dbg_map_pkg.sv
verilog/dbg_types_pkg.sv
verilog/dbg_apb_slave.sv
verilog/dbg_ctrl_unit.sv
verilog/core_state_model.sv
verilog/dbg_subsys_top.sv
tests/tb_dbg_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the debug subsystem regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_dbg_subsys -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
